//--- source/cache_pkg.sv
//##########################################################################
// geometry is fixed here, 8 sets x 2 ways x 2 words (128 bytes of data)
// addresses from NONCACHE_START upward bypass the cache
// only a two-way set with one lru bit per set is supported
//##########################################################################
package cache_pkg;

    localparam int WORD_BYTES  = 4;  // byte lanes per word
    localparam int BLOCK_WORDS = 2;  // words per block
    localparam int N_WAYS      = 2;
    localparam int N_SETS      = 8;
    localparam int SET_BITS    = 3;  // log2(N_SETS)
    localparam int BLOCK_BITS  = 1;  // log2(BLOCK_WORDS)
    localparam int TAG_BITS    = 26; // 32 - set - word - 2 byte bits

    localparam logic [31:0] NONCACHE_START = 32'h8000_0000;

    typedef logic [31:0] word_t;

    // processor byte address split into cache fields
    typedef struct packed {
        logic [TAG_BITS-1:0]   tag;
        logic [SET_BITS-1:0]   set_idx;
        logic [BLOCK_BITS-1:0] word_idx;
        logic [1:0]            byte_idx; // always 0 on block transfers
    } addr_fields_t;

    // one way of one set, as seen from outside the array
    typedef struct packed {
        logic                     valid;
        logic                     dirty;
        logic [TAG_BITS-1:0]      tag;
        word_t [BLOCK_WORDS-1:0]  data;  // data[0] is the lower address
    } frame_t;

    // replace the enabled byte lanes of old_w with the lanes of new_w
    function automatic word_t merge_bytes(
        input word_t                 old_w,
        input word_t                 new_w,
        input logic [WORD_BYTES-1:0] be
    );
        word_t res;
        res = old_w;
        for (int i = 0; i < WORD_BYTES; i++) begin
            if (be[i]) begin
                res[8*i +: 8] = new_w[8*i +: 8]; // lane i is bits 8i+7..8i
            end
        end
        return res;
    endfunction

endpackage

//--- source/cache_array_if.sv
`timescale 1ns/1ns
//##########################################################################
// link between cache controller and frame storage
// scan_set/scan_way address fills, cleans and scan_frame reads
//##########################################################################
interface cache_array_if
    import cache_pkg::*;
();

    // lookup results, combinational from lookup_addr
    logic                  hit;
    logic                  hit_way;
    word_t                 hit_word;     // addressed word of the hit way
    logic                  victim_way;   // lru choice for the lookup set
    frame_t                victim_frame;
    frame_t                scan_frame;   // frame at scan_set/scan_way

    // commands from the controller, applied at the next edge
    addr_fields_t          lookup_addr;
    logic                  touch;        // mark hit_way as most recent
    logic                  wr_hit;       // byte-merge wr_data into hit word
    word_t                 wr_data;
    logic [WORD_BYTES-1:0] wr_be;
    logic                  fill_word;    // store one fetched word
    logic [BLOCK_BITS-1:0] fill_idx;
    word_t                 fill_data;
    logic                  fill_done;    // valid=1, tag from lookup_addr, dirty=0
    logic                  clean;        // dirty=0 at scan_set/scan_way
    logic [SET_BITS-1:0]   scan_set;
    logic                  scan_way;

    modport ctrl (
        input  hit, hit_way, hit_word, victim_way, victim_frame, scan_frame,
        output lookup_addr, touch, wr_hit, wr_data, wr_be,
        output fill_word, fill_idx, fill_data, fill_done, clean, scan_set, scan_way
    );

    modport array (
        output hit, hit_way, hit_word, victim_way, victim_frame, scan_frame,
        input  lookup_addr, touch, wr_hit, wr_data, wr_be,
        input  fill_word, fill_idx, fill_data, fill_done, clean, scan_set, scan_way
    );

endinterface

//--- source/cache_array.sv
`timescale 1ns/1ns
//##########################################################################
// frame storage for a two-way set associative cache
// only valid, dirty and lru bits are cleared by reset
// tag and data of an invalid frame hold whatever was there before
//##########################################################################
module cache_array
    import cache_pkg::*;
(
    input logic          CLK,
    input logic          nRST,
    cache_array_if.array bus
);

    logic [N_WAYS-1:0]       valid_q [N_SETS];
    logic [N_WAYS-1:0]       dirty_q [N_SETS];
    logic [TAG_BITS-1:0]     tag_q   [N_SETS][N_WAYS];
    word_t [BLOCK_WORDS-1:0] data_q  [N_SETS][N_WAYS];
    logic [N_SETS-1:0]       lru_q;  // way used last, the other one is evicted

    addr_fields_t      la;
    logic [N_WAYS-1:0] match;
    logic              hit_way;
    word_t             hit_word;
    logic              vic_way;

    assign la = bus.lookup_addr;

    // tag compare across both ways of the selected set
    always_comb begin
        for (int w = 0; w < N_WAYS; w++) begin
            match[w] = valid_q[la.set_idx][w] && (tag_q[la.set_idx][w] == la.tag);
        end
    end

    assign hit_way  = match[1];                  // way 0 unless way 1 matched
    assign hit_word = data_q[la.set_idx][hit_way][la.word_idx];
    assign vic_way  = ~lru_q[la.set_idx];

    assign bus.hit        = |match;
    assign bus.hit_way    = hit_way;
    assign bus.hit_word   = hit_word;
    assign bus.victim_way = vic_way;

    // whole-frame views, victim for the miss decision, scan for write-back
    always_comb begin
        bus.victim_frame.valid = valid_q[la.set_idx][vic_way];
        bus.victim_frame.dirty = dirty_q[la.set_idx][vic_way];
        bus.victim_frame.tag   = tag_q[la.set_idx][vic_way];
        bus.victim_frame.data  = data_q[la.set_idx][vic_way];

        bus.scan_frame.valid   = valid_q[bus.scan_set][bus.scan_way];
        bus.scan_frame.dirty   = dirty_q[bus.scan_set][bus.scan_way];
        bus.scan_frame.tag     = tag_q[bus.scan_set][bus.scan_way];
        bus.scan_frame.data    = data_q[bus.scan_set][bus.scan_way];
    end

    // data and tag write port
    always_ff @(posedge CLK) begin
        if (bus.wr_hit) begin
            // only the enabled lanes change
            data_q[la.set_idx][hit_way][la.word_idx] <=
                merge_bytes(hit_word, bus.wr_data, bus.wr_be);
        end
        if (bus.fill_word) begin
            data_q[bus.scan_set][bus.scan_way][bus.fill_idx] <= bus.fill_data;
        end
        if (bus.fill_done) begin
            tag_q[bus.scan_set][bus.scan_way] <= la.tag; // lookup holds the fetched block
        end
    end

    // frame state and replacement bits
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < N_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
            lru_q <= '0;
        end else begin
            if (bus.wr_hit) begin
                dirty_q[la.set_idx][hit_way] <= 1'b1;
            end
            if (bus.touch) begin
                lru_q[la.set_idx] <= hit_way;
            end
            if (bus.fill_done) begin
                valid_q[bus.scan_set][bus.scan_way] <= 1'b1;
                dirty_q[bus.scan_set][bus.scan_way] <= 1'b0;   // fresh copy of memory
            end
            if (bus.clean) begin
                dirty_q[bus.scan_set][bus.scan_way] <= 1'b0;
            end
        end
    end

    // a block lives in one way only, so fills must never duplicate a tag
    a_single_way_match: assert property (
        @(posedge CLK) disable iff (!nRST) !(match[0] && match[1])
    );

    // hit writes come only from a lookup that actually hit
    a_write_needs_hit: assert property (
        @(posedge CLK) disable iff (!nRST) bus.wr_hit |-> bus.hit
    );

endmodule

//--- source/cache_ctrl.sv
`timescale 1ns/1ns
//##########################################################################
// miss, write-back, pass-through and flush control
// processor holds ren/wen and inputs stable until busy is seen low
// flush is taken only in IDLE with no request, drop it after flush_done
//##########################################################################
module cache_ctrl
    import cache_pkg::*;
(
    input  logic          CLK,
    input  logic          nRST,
    cache_array_if.ctrl   arr,
    input  word_t         proc_addr,
    input  word_t         proc_wdata,
    input  logic          proc_ren,
    input  logic          proc_wen,
    input  logic [3:0]    proc_byte_en,
    output word_t         proc_rdata,
    output logic          proc_busy,
    output word_t         mem_addr,
    output word_t         mem_wdata,
    output logic          mem_ren,
    output logic          mem_wen,
    output logic [3:0]    mem_byte_en,
    input  word_t         mem_rdata,
    input  logic          mem_busy,
    input  logic          flush,
    output logic          flush_done
);

    typedef enum logic [2:0] {IDLE, FETCH, WB, FLUSH_SCAN, FLUSH_WB} state_t;

    state_t                state, next_state;
    addr_fields_t          req;
    addr_fields_t          blk_q;        // block being filled, word/byte fields zero
    logic [TAG_BITS-1:0]   vic_tag_q;
    logic                  vic_way_q;
    logic                  latch_miss;
    logic [BLOCK_BITS-1:0] word_cnt, next_word_cnt;
    logic [SET_BITS:0]     scan_cnt, next_scan_cnt; // {set, way}, way in bit 0
    logic                  req_any;
    logic                  pass;
    logic                  scanning;
    logic                  last_word;
    logic                  last_frame;
    logic                  flush_done_q, next_flush_done;

    assign req        = proc_addr;
    assign req_any    = proc_ren | proc_wen;
    assign pass       = (proc_addr >= NONCACHE_START);
    assign scanning   = (state == FLUSH_SCAN) || (state == FLUSH_WB);
    assign last_word  = (word_cnt == BLOCK_BITS'(BLOCK_WORDS - 1));
    assign last_frame = &scan_cnt;   // last set, way 1
    assign flush_done = flush_done_q;

    // flush walks the scan counter, a miss targets the latched set and victim
    assign arr.scan_set = scanning ? scan_cnt[SET_BITS:1] : blk_q.set_idx;
    assign arr.scan_way = scanning ? scan_cnt[0] : vic_way_q;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state        <= IDLE;
            word_cnt     <= '0;
            scan_cnt     <= '0;
            flush_done_q <= 1'b0;
        end else begin
            state        <= next_state;
            word_cnt     <= next_word_cnt;
            scan_cnt     <= next_scan_cnt;
            flush_done_q <= next_flush_done;
        end
    end

    // miss bookkeeping, captured once in IDLE
    always_ff @(posedge CLK) begin
        if (latch_miss) begin
            blk_q     <= {req.tag, req.set_idx, BLOCK_BITS'(0), 2'b00};
            vic_way_q <= arr.victim_way;
            vic_tag_q <= arr.victim_frame.tag;
        end
    end

    always_comb begin
        next_state      = state;
        next_word_cnt   = word_cnt;
        next_scan_cnt   = scan_cnt;
        next_flush_done = 1'b0;
        latch_miss      = 1'b0;

        proc_busy   = req_any;      // busy only while something is asked
        proc_rdata  = arr.hit_word;
        mem_addr    = proc_addr;
        mem_wdata   = proc_wdata;
        mem_byte_en = proc_byte_en;
        mem_ren     = 1'b0;
        mem_wen     = 1'b0;

        arr.lookup_addr = {blk_q.tag, blk_q.set_idx, word_cnt, 2'b00};
        arr.touch       = 1'b0;
        arr.wr_hit      = 1'b0;
        arr.wr_data     = proc_wdata;
        arr.wr_be       = proc_byte_en;
        arr.fill_word   = 1'b0;
        arr.fill_idx    = word_cnt;
        arr.fill_data   = mem_rdata;
        arr.fill_done   = 1'b0;
        arr.clean       = 1'b0;

        case (state)
            IDLE: begin
                arr.lookup_addr = proc_addr;
                if (req_any && pass) begin
                    // uncached, memory port follows the processor
                    mem_ren    = proc_ren;
                    mem_wen    = proc_wen;
                    proc_busy  = mem_busy;
                    proc_rdata = mem_rdata;
                end else if (req_any && arr.hit) begin
                    proc_busy  = 1'b0;           // zero-wait hit
                    arr.touch  = 1'b1;
                    arr.wr_hit = proc_wen;
                end else if (req_any) begin
                    latch_miss    = 1'b1;
                    next_word_cnt = '0;
                    next_state    = arr.victim_frame.dirty ? WB : FETCH;
                end else if (flush && !flush_done_q) begin
                    next_scan_cnt = '0;
                    next_state    = FLUSH_SCAN;
                end
            end
            WB: begin
                // evict the victim one word per not-busy cycle
                mem_wen     = 1'b1;
                mem_addr    = {vic_tag_q, blk_q.set_idx, word_cnt, 2'b00};
                mem_wdata   = arr.scan_frame.data[word_cnt];
                mem_byte_en = '1;
                if (!mem_busy) begin
                    next_word_cnt = word_cnt + 1'b1;
                    if (last_word) begin
                        arr.clean     = 1'b1;
                        next_word_cnt = '0;
                        next_state    = FETCH;
                    end
                end
            end
            FETCH: begin
                mem_ren     = 1'b1;
                mem_addr    = {blk_q.tag, blk_q.set_idx, word_cnt, 2'b00};
                mem_byte_en = '1;
                if (!mem_busy) begin
                    arr.fill_word = 1'b1;
                    next_word_cnt = word_cnt + 1'b1;
                    if (last_word) begin
                        arr.fill_done = 1'b1;        // request hits next cycle
                        next_word_cnt = '0;
                        next_state    = IDLE;
                    end
                end
            end
            FLUSH_SCAN: begin
                if (arr.scan_frame.dirty) begin
                    next_word_cnt = '0;
                    next_state    = FLUSH_WB;
                end else if (last_frame) begin
                    next_scan_cnt   = '0;
                    next_flush_done = 1'b1;          // pulse lands in IDLE
                    next_state      = IDLE;
                end else begin
                    next_scan_cnt = scan_cnt + 1'b1;
                end
            end
            FLUSH_WB: begin
                mem_wen     = 1'b1;
                mem_addr    = {arr.scan_frame.tag, scan_cnt[SET_BITS:1], word_cnt, 2'b00};
                mem_wdata   = arr.scan_frame.data[word_cnt];
                mem_byte_en = '1;
                if (!mem_busy) begin
                    next_word_cnt = word_cnt + 1'b1;
                    if (last_word) begin
                        arr.clean     = 1'b1;        // rescan sees it clean and moves on
                        next_word_cnt = '0;
                        next_state    = FLUSH_SCAN;
                    end
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // pass-through relies on the processor never asking for both
    a_mem_rw_exclusive: assert property (
        @(posedge CLK) disable iff (!nRST) !(mem_ren && mem_wen)
    );

endmodule

//--- source/l1_cache.sv
`timescale 1ns/1ns
//##########################################################################
// write-back L1 data cache, 2-way, zero-wait hits
// memory port is word wide, block transfers use all four byte enables
//##########################################################################
module l1_cache
    import cache_pkg::*;
(
    input  logic       CLK,
    input  logic       nRST,

    // processor side
    input  word_t      proc_addr,
    input  word_t      proc_wdata,
    input  logic       proc_ren,
    input  logic       proc_wen,
    input  logic [3:0] proc_byte_en,
    output word_t      proc_rdata,
    output logic       proc_busy,

    // memory side
    output word_t      mem_addr,
    output word_t      mem_wdata,
    output logic       mem_ren,
    output logic       mem_wen,
    output logic [3:0] mem_byte_en,
    input  word_t      mem_rdata,
    input  logic       mem_busy,

    // whole-cache write-back
    input  logic       flush,
    output logic       flush_done
);

    cache_array_if arr_if ();

    cache_array u_array (
        .CLK  (CLK),
        .nRST (nRST),
        .bus  (arr_if.array)
    );

    cache_ctrl u_ctrl (
        .CLK          (CLK),
        .nRST         (nRST),
        .arr          (arr_if.ctrl),
        .proc_addr    (proc_addr),
        .proc_wdata   (proc_wdata),
        .proc_ren     (proc_ren),
        .proc_wen     (proc_wen),
        .proc_byte_en (proc_byte_en),
        .proc_rdata   (proc_rdata),
        .proc_busy    (proc_busy),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_ren      (mem_ren),
        .mem_wen      (mem_wen),
        .mem_byte_en  (mem_byte_en),
        .mem_rdata    (mem_rdata),
        .mem_busy     (mem_busy),
        .flush        (flush),
        .flush_done   (flush_done)
    );

endmodule

//--- testbench/tb_mem_model.sv
`timescale 1ns/1ns
//##########################################################################
// word memory with 256 words at 0 and 256 words at NONCACHE_START
// address bits outside those two 1 KB windows are ignored
// busy follows the stall input while a transfer is asked for
//##########################################################################
module tb_mem_model
    import cache_pkg::*;
(
    input  logic       CLK,
    input  word_t      addr,
    input  word_t      wdata,
    input  logic       ren,
    input  logic       wen,
    input  logic [3:0] byte_en,
    input  logic       stall,    // wait state request from the testbench
    output word_t      rdata,
    output logic       busy
);

    word_t      mem [512];       // low half cacheable, high half pass-through
    logic [8:0] idx;
    word_t      merged;

    assign idx   = {addr[31], addr[9:2]};
    assign busy  = stall & (ren | wen);
    assign rdata = mem[idx];     // read data is combinational

    // start-up contents, every address bit changes the word
    initial begin
        word_t a;
        for (int i = 0; i < 512; i++) begin
            a      = {i[8], 21'd0, i[7:0], 2'b00};
            mem[i] = a ^ {a[15:0], a[31:16]} ^ 32'h6b3d_91c5;
        end
    end

    // a write lands at the edge where it is not stalled
    always @(posedge CLK) begin
        if (wen && !busy) begin
            merged = mem[idx];
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    merged[8*b +: 8] = wdata[8*b +: 8]; // lane b only
                end
            end
            mem[idx] <= merged;
        end
    end

endmodule

//--- testbench/tb_l1_cache.sv
`timescale 1ns/1ns
//##########################################################################
// testbench for l1_cache against a flat shadow memory
// stimulus stays inside the two 1 KB windows of tb_mem_model
// random stimulus and wait states come from one lfsr stream
//##########################################################################
module tb_l1_cache
    import cache_pkg::*;
();

    localparam int PERIOD     = 40;
    localparam int REQ_BUDGET = 320;  // all requests plus flush frames, rounded up
    localparam int WORST_CYC  = 40;   // dirty miss with wait states

    logic        CLK = 1'b0;
    logic        nRST;
    word_t       proc_addr, proc_wdata, proc_rdata;
    logic        proc_ren, proc_wen, proc_busy;
    logic [3:0]  proc_byte_en;
    word_t       mem_addr, mem_wdata, mem_rdata;
    logic        mem_ren, mem_wen, mem_busy;
    logic [3:0]  mem_byte_en;
    logic        flush, flush_done;
    logic        stall;

    logic [31:0] lfsr_q;
    word_t       shadow [512];        // same word layout as the memory model
    logic        written [512];
    word_t       exp_q [$];           // expected read data, oldest first
    string       name_q [$];
    int          n_checks, n_errors, err_mark;
    int          tests_passed, tests_failed;
    int          wait_cycles;         // busy edges seen by the last request

    always #(PERIOD/2) CLK = ~CLK;

    l1_cache u_dut (
        .CLK (CLK), .nRST (nRST),
        .proc_addr (proc_addr), .proc_wdata (proc_wdata), .proc_ren (proc_ren),
        .proc_wen (proc_wen), .proc_byte_en (proc_byte_en),
        .proc_rdata (proc_rdata), .proc_busy (proc_busy),
        .mem_addr (mem_addr), .mem_wdata (mem_wdata), .mem_ren (mem_ren),
        .mem_wen (mem_wen), .mem_byte_en (mem_byte_en),
        .mem_rdata (mem_rdata), .mem_busy (mem_busy),
        .flush (flush), .flush_done (flush_done)
    );

    tb_mem_model u_mem (
        .CLK (CLK), .addr (mem_addr), .wdata (mem_wdata), .ren (mem_ren),
        .wen (mem_wen), .byte_en (mem_byte_en), .stall (stall),
        .rdata (mem_rdata), .busy (mem_busy)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            r      = {r[30:0], lfsr_q[0]};  // one step per bit
        end
        return r;
    endfunction

    function automatic int widx(input word_t a);
        return {a[31], a[9:2]};
    endfunction

    function automatic word_t cached_addr(input logic [3:0] tag, input logic [2:0] set_i,
                                          input logic w);
        return {22'd0, tag, set_i, w, 2'b00};   // tag lands in bits 9:6
    endfunction

    function automatic word_t pass_addr(input logic [7:0] w);
        return NONCACHE_START | {22'd0, w, 2'b00};
    endfunction

    // transparent cache means reads return what a flat memory holds
    function automatic word_t ref_access(input word_t addr, input logic wr,
                                         input word_t wdata, input logic [3:0] be);
        word_t mask;
        int    i;
        i    = widx(addr);
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        if (wr) begin
            shadow[i]  = (shadow[i] & ~mask) | (wdata & mask);
            written[i] = 1'b1;
        end
        return shadow[i];
    endfunction

    task automatic check(input string name, input word_t exp, input word_t act);
        n_checks++;
        if (exp !== act) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            n_errors++;
        end
    endtask

    // every read that completes is compared in order of issue
    always @(posedge CLK) begin
        if (nRST && proc_ren && !proc_busy) begin
            if (exp_q.size() == 0) begin
                $display("a read completed that the testbench never issued");
                n_errors++;
            end else begin
                check(name_q.pop_front(), exp_q.pop_front(), proc_rdata);
            end
        end
    end

    task automatic tick();
        @(negedge CLK);
        stall = (take_bits(2) == 32'd3);    // about one cycle in four
    endtask

    task automatic idle_cycle();
        tick();
        proc_ren = 1'b0;
        proc_wen = 1'b0;
    endtask

    // hold one request until busy is low at a rising edge
    task automatic access(input string name, input word_t addr, input logic wr,
                          input word_t wdata, input logic [3:0] be);
        word_t exp;
        exp = ref_access(addr, wr, wdata, be);
        tick();
        if (!wr) begin
            exp_q.push_back(exp);
            name_q.push_back(name);
        end
        proc_addr    = addr;
        proc_wdata   = wdata;
        proc_byte_en = wr ? be : 4'hf;
        proc_ren     = !wr;
        proc_wen     = wr;
        wait_cycles  = 0;
        @(posedge CLK);
        while (proc_busy) begin
            wait_cycles++;
            tick();
            @(posedge CLK);
        end
    endtask

    task automatic compare_mem(input string name, input word_t addr);
        check(name, shadow[widx(addr)], u_mem.mem[widx(addr)]);
    endtask

    task automatic do_flush(input string name);
        idle_cycle();
        flush = 1'b1;
        @(posedge CLK);
        while (!flush_done) begin
            tick();
            @(posedge CLK);
        end
        tick();
        flush = 1'b0;
        check(name, 32'd0, {31'd0, flush_done});   // pulse is one cycle wide
    endtask

    task automatic end_test(input string name);
        idle_cycle();
        if (exp_q.size() != 0) begin
            $display("test %s ended with %0d reads never completed", name, exp_q.size());
            n_errors++;
            exp_q.delete();
            name_q.delete();
        end
        if (n_errors == err_mark) begin
            tests_passed++;
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, n_errors - err_mark);
        end
        err_mark = n_errors;
    endtask

    initial begin
        string       tn;
        word_t       a;
        word_t       d;
        logic [3:0]  be;
        logic [31:0] r;
        logic [23:0] masks;
        nRST         = 1'b0;
        proc_addr    = '0;
        proc_wdata   = '0;
        proc_ren     = 1'b0;
        proc_wen     = 1'b0;
        proc_byte_en = '0;
        flush        = 1'b0;
        stall        = 1'b0;
        lfsr_q       = 32'd97900;
        n_checks     = 0;
        n_errors     = 0;
        err_mark     = 0;
        tests_passed = 0;
        tests_failed = 0;
        wait_cycles  = 0;
        repeat (16) @(negedge CLK);
        nRST = 1'b1;
        for (int i = 0; i < 512; i++) begin
            shadow[i]  = u_mem.mem[i];     // start from the model's fill
            written[i] = 1'b0;
        end

        tn = "write_read_hits";
        for (int i = 0; i < 16; i++) begin
            d = take_bits(32);
            access(tn, cached_addr(4'd1, i[2:0], i[0]), i < 8 ? 1'b1 : 1'b0, d, 4'hf);
            if (i >= 8) begin
                check(tn, 32'd0, word_t'(wait_cycles));   // read hit, zero wait
            end
        end
        end_test(tn);

        tn    = "byte_enables";
        masks = 24'h95c341;               // single, half-word and mixed lanes
        for (int i = 0; i < 6; i++) begin
            be = masks[4*i +: 4];
            a  = cached_addr(4'd2, i[2:0], 1'b1);
            d  = take_bits(32);
            access(tn, a, 1'b1, d, be);
            access(tn, a, 1'b0, 32'd0, 4'hf);
            a  = pass_addr(i[7:0]);
            d  = take_bits(32);
            access(tn, a, 1'b1, d, be);
            access(tn, a, 1'b0, 32'd0, 4'hf);
        end
        end_test(tn);

        tn = "dirty_eviction";
        for (int t = 3; t < 6; t++) begin
            d = take_bits(32);
            access(tn, cached_addr(t[3:0], 3'd5, 1'b0), 1'b1, d, 4'hf);
        end
        idle_cycle();
        compare_mem(tn, cached_addr(4'd3, 3'd5, 1'b0));  // oldest tag went out
        for (int t = 3; t < 6; t++) begin
            access(tn, cached_addr(t[3:0], 3'd5, 1'b0), 1'b0, 32'd0, 4'hf);
        end
        idle_cycle();
        for (int t = 3; t < 6; t++) begin
            compare_mem(tn, cached_addr(t[3:0], 3'd5, 1'b0));
            compare_mem(tn, cached_addr(t[3:0], 3'd5, 1'b1));
        end
        end_test(tn);

        tn = "pass_through";
        for (int i = 0; i < 4; i++) begin
            a = pass_addr(8'h40 + i[7:0]);
            d = take_bits(32);
            access(tn, a, 1'b1, d, 4'hf);
            idle_cycle();
            compare_mem(tn, a);            // already in memory, no flush
            access(tn, a, 1'b0, 32'd0, 4'hf);
        end
        end_test(tn);

        tn = "flush";
        for (int i = 0; i < 8; i++) begin
            d  = take_bits(32);
            be = 4'(take_bits(4));
            access(tn, cached_addr(4'd6, i[2:0], i[0]), 1'b1, d, be);
        end
        do_flush(tn);
        for (int i = 0; i < 512; i++) begin
            if (written[i]) begin
                check(tn, shadow[i], u_mem.mem[i]);
            end
        end
        end_test(tn);

        tn = "random_mix";
        for (int n = 0; n < 200; n++) begin
            r  = take_bits(14);
            d  = take_bits(32);
            be = 4'(take_bits(4));
            if (r[13]) begin
                a = pass_addr(r[7:0]);
            end else begin
                a = cached_addr(r[7:4], r[3:1], r[0]);  // 16 tags per set
            end
            access(tn, a, r[12], d, be);
        end
        end_test(tn);

        $display("tests passed %0d failed %0d, checks %0d, errors %0d",
                 tests_passed, tests_failed, n_checks, n_errors);
        if (tests_failed == 0 && n_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // twice the worst case for every request of the run
    initial begin
        #(REQ_BUDGET * WORST_CYC * PERIOD * 2);
        $display("run timed out before all tests finished");
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- tb.f
source/cache_pkg.sv
source/cache_array_if.sv
source/cache_array.sv
source/cache_ctrl.sv
source/l1_cache.sv
testbench/tb_mem_model.sv
testbench/tb_l1_cache.sv
